// File: Makefile
TOP = noc_chain_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f noc_chain.f --top-module $(TOP) -Mdir obj_dir

# Pass only when the testbench prints its pass line
run: compile
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf obj_dir

// File: noc_chain.f
verilog/noc_pkg.sv
verilog/fir_filter.sv
verilog/traffic_gen.sv
verilog/pipe_reg.sv
verilog/hop_stage.sv
verilog/traffic_sink.sv
verilog/noc_chain_top.sv
tb/noc_chain_props.sv
tb/noc_chain_tb.sv

// File: tb/noc_chain_props.sv
`default_nettype none

module noc_chain_props (
    input logic           clk,
    input logic           reset,
    input noc_pkg::link_t out_link,
    input logic           out_ready,
    input logic           seq_error,
    input logic [31:0]    flit_count
);

    // Outputs idle while reset is held
    reset_idle: assert property (
        @(posedge clk) reset |-> !out_link.valid && !seq_error && flit_count == 32'd0
    ) else $error("Outputs not idle while reset is asserted");

    // First cycle out of reset still clean
    after_reset_idle: assert property (
        @(posedge clk) $fell(reset) |-> !out_link.valid && !seq_error && flit_count == 32'd0
    ) else $error("Outputs not idle on the first cycle after reset");

    // Sink sequence check never trips
    seq_ok: assert property (
        @(posedge clk) disable iff (reset) !seq_error
    ) else $error("Sink flagged an out-of-order flit");

    // A stalled flit stays put until taken
    hold_on_stall: assert property (
        @(posedge clk) disable iff (reset)
        out_link.valid && !out_ready |=> out_link.valid && $stable(out_link.flit)
    ) else $error("Output flit changed or dropped while stalled");

    // Sink register full and stalled, so no new flit is taken in
    count_hold_on_stall: assert property (
        @(posedge clk) disable iff (reset)
        out_link.valid && !out_ready |=> $stable(flit_count)
    ) else $error("Delivered-flit counter moved while the output was stalled");

endmodule

bind noc_chain_top noc_chain_props noc_chain_props_inst (
    .clk        (clk),
    .reset      (reset),
    .out_link   (out_link),
    .out_ready  (out_ready),
    .seq_error  (seq_error),
    .flit_count (flit_count)
);

`default_nettype wire

// File: tb/noc_chain_tb.sv
`default_nettype none

module noc_chain_tb;

    localparam int NUM_HOPS     = 7;
    localparam int NUM_FLITS    = 300;
    localparam int MAX_CYCLES   = NUM_FLITS * 8 + 200;
    localparam int RESET_CYCLES = 10;
    localparam int STALL_START  = 150;
    localparam int STALL_LEN    = 20;
    localparam int SW           = noc_pkg::SAMPLE_W;

    // Chain constants, newest tap first
    localparam int            COEF [4]  = '{1, 2, 2, 1};
    localparam logic [SW-1:0] BASE_KEY  = 18'h2D5A3;
    localparam int            RAMP_STEP = 4;

    logic           clk;
    logic           reset;
    logic           enable;
    logic           out_ready;
    noc_pkg::link_t out_link;
    logic           seq_error;
    logic [31:0]    flit_count;

    // Reference model state
    logic [SW-1:0] ramp = '0;
    logic [SW-1:0] history [3] = '{'0, '0, '0};

    int cycles        = 0;
    int delivered     = 0;
    int sample_errors = 0;
    int seq_errors    = 0;
    int count_errors  = 0;
    int flag_errors   = 0;
    bit timed_out     = 1'b0;

    noc_chain_top #(
        .NUM_HOPS (NUM_HOPS)
    ) noc_chain_top_inst (
        .clk        (clk),
        .reset      (reset),
        .enable     (enable),
        .out_link   (out_link),
        .out_ready  (out_ready),
        .seq_error  (seq_error),
        .flit_count (flit_count)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // One hop: rotate left by one, then XOR with the hop's key
    function automatic logic [SW-1:0] mix_for_hop(input logic [SW-1:0] sample, input int hop);
        logic [SW-1:0] key;
        key = BASE_KEY + SW'(hop);
        return {sample[SW-2:0], sample[SW-1]} ^ key;
    endfunction

    // Next delivered sample: FIR of the ramp, then every hop in order
    task automatic predict_sample(output logic [SW-1:0] expected);
        int            sum;
        logic [SW-1:0] s;
        sum = COEF[0] * int'(ramp) + COEF[1] * int'(history[0])
            + COEF[2] * int'(history[1]) + COEF[3] * int'(history[2]);
        s = SW'(sum);
        history[2] = history[1];
        history[1] = history[0];
        history[0] = ramp;
        ramp = ramp + SW'(RAMP_STEP);
        for (int h = 0; h < NUM_HOPS; h++) begin
            s = mix_for_hop(s, h);
        end
        expected = s;
    endtask

    // Outputs are settled by the falling edge
    always @(negedge clk) begin
        logic [SW-1:0]             exp_sample;
        logic [noc_pkg::SEQ_W-1:0] exp_seq;
        if (!reset) begin
            // Sink register may hold one flit not yet delivered
            assert (flit_count == 32'(delivered) + 32'(out_link.valid)) else begin
                $display("MISMATCH flit_count: expected %0d, actual %0d",
                         delivered + int'(out_link.valid), flit_count);
                count_errors++;
            end
            if (out_link.valid && out_ready) begin
                predict_sample(exp_sample);
                exp_seq = noc_pkg::SEQ_W'(delivered);
                assert (out_link.flit.sample == exp_sample) else begin
                    $display("MISMATCH sample of flit %0d: expected 0x%05h, actual 0x%05h",
                             delivered, exp_sample, out_link.flit.sample);
                    sample_errors++;
                end
                assert (out_link.flit.seq == exp_seq) else begin
                    $display("MISMATCH seq of flit %0d: expected %0d, actual %0d",
                             delivered, exp_seq, out_link.flit.seq);
                    seq_errors++;
                end
                assert (!seq_error) else begin
                    $display("Sink raised seq_error before flit %0d was delivered", delivered);
                    flag_errors++;
                end
                delivered++;
            end
        end
    end

    initial begin
        int total;
        void'($urandom(26));
        reset     = 1'b1;
        enable    = 1'b0;
        out_ready = 1'b0;
        repeat (RESET_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        reset <= 1'b0;

        while (delivered < NUM_FLITS && !timed_out) begin
            @(posedge clk);
            cycles++;
            // Mostly enabled, with random single-cycle gaps
            enable <= ($urandom % 8) != 0;
            // Long stall once, otherwise ready about 70% of cycles
            if (cycles >= STALL_START && cycles < STALL_START + STALL_LEN) begin
                out_ready <= 1'b0;
            end else begin
                out_ready <= ($urandom % 10) < 7;
            end
            if (cycles >= MAX_CYCLES) begin
                timed_out = 1'b1;
            end
        end

        if (timed_out) begin
            $display("Run timed out after %0d cycles with %0d of %0d flits delivered",
                     cycles, delivered, NUM_FLITS);
        end
        total = sample_errors + seq_errors + count_errors + flag_errors;
        $display("Errors: sample %0d, seq %0d, flit_count %0d, seq_error %0d, total %0d",
                 sample_errors, seq_errors, count_errors, flag_errors, total);
        if (timed_out || total != 0) begin
            $display("TEST FAILED");
        end else begin
            $display("TEST PASSED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/fir_filter.sv
`default_nettype none

module fir_filter (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         shift,
    input  logic [noc_pkg::SAMPLE_W-1:0] sample_in,
    output logic [noc_pkg::SAMPLE_W-1:0] sum_out
);

    // Past samples, taps[0] is the most recent
    logic [noc_pkg::SAMPLE_W-1:0] taps [noc_pkg::NUM_TAPS-1];

    // Current sample followed by the delay line
    logic [noc_pkg::SAMPLE_W-1:0] window [noc_pkg::NUM_TAPS];

    always_comb begin
        window[0] = sample_in;
        for (int i = 1; i < noc_pkg::NUM_TAPS; i++) begin
            window[i] = taps[i-1];
        end
    end

    // Weighted sum wraps at the sample width
    always_comb begin
        sum_out = '0;
        for (int i = 0; i < noc_pkg::NUM_TAPS; i++) begin
            sum_out = sum_out
                    + noc_pkg::SAMPLE_W'(noc_pkg::FIR_COEF[i] * window[i]);
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < noc_pkg::NUM_TAPS - 1; i++) begin
                taps[i] <= '0;
            end
        end else if (shift) begin
            taps[0] <= sample_in;
            for (int i = 1; i < noc_pkg::NUM_TAPS - 1; i++) begin
                taps[i] <= taps[i-1];
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/hop_stage.sv
`default_nettype none

module hop_stage #(
    parameter int HOP_ID = 0
) (
    input  logic           clk,
    input  logic           reset,
    input  noc_pkg::link_t in_link,
    output logic           in_ready,
    output noc_pkg::link_t out_link,
    input  logic           out_ready
);

    // Each hop gets its own key
    localparam logic [noc_pkg::SAMPLE_W-1:0] MIX_KEY =
        noc_pkg::SAMPLE_W'(noc_pkg::HOP_KEY + HOP_ID);

    noc_pkg::link_t               buf_link;
    noc_pkg::link_t               mix_link;
    logic                         mix_ready;
    logic [noc_pkg::SAMPLE_W-1:0] rot_sample;

    // Input buffer
    pipe_reg in_buf_inst (
        .clk       (clk),
        .reset     (reset),
        .in_link   (in_link),
        .in_ready  (in_ready),
        .out_link  (buf_link),
        .out_ready (mix_ready)
    );

    // Rotate left by one within the sample
    assign rot_sample = {buf_link.flit.sample[noc_pkg::SAMPLE_W-2:0],
                         buf_link.flit.sample[noc_pkg::SAMPLE_W-1]};

    // seq and valid pass straight through the mix
    assign mix_link = '{
        valid: buf_link.valid,
        flit:  '{seq: buf_link.flit.seq, sample: rot_sample ^ MIX_KEY}
    };

    // Output buffer
    pipe_reg out_buf_inst (
        .clk       (clk),
        .reset     (reset),
        .in_link   (mix_link),
        .in_ready  (mix_ready),
        .out_link  (out_link),
        .out_ready (out_ready)
    );

endmodule

`default_nettype wire

// File: verilog/noc_chain_top.sv
`default_nettype none

module noc_chain_top #(
    parameter int NUM_HOPS = 7
) (
    input  logic           clk,
    input  logic           reset,
    input  logic           enable,
    output noc_pkg::link_t out_link,
    input  logic           out_ready,
    output logic           seq_error,
    output logic [31:0]    flit_count
);

    // Link h feeds hop h, link NUM_HOPS feeds the sink
    noc_pkg::link_t chain_link  [NUM_HOPS+1];
    logic           chain_ready [NUM_HOPS+1];

    traffic_gen traffic_gen_inst (
        .clk       (clk),
        .reset     (reset),
        .enable    (enable),
        .out_link  (chain_link[0]),
        .out_ready (chain_ready[0])
    );

    for (genvar h = 0; h < NUM_HOPS; h++) begin : g_hop
        hop_stage #(
            .HOP_ID (h)
        ) hop_stage_inst (
            .clk       (clk),
            .reset     (reset),
            .in_link   (chain_link[h]),
            .in_ready  (chain_ready[h]),
            .out_link  (chain_link[h+1]),
            .out_ready (chain_ready[h+1])
        );
    end

    traffic_sink traffic_sink_inst (
        .clk        (clk),
        .reset      (reset),
        .in_link    (chain_link[NUM_HOPS]),
        .in_ready   (chain_ready[NUM_HOPS]),
        .out_link   (out_link),
        .out_ready  (out_ready),
        .seq_error  (seq_error),
        .flit_count (flit_count)
    );

endmodule

`default_nettype wire

// File: verilog/noc_pkg.sv
`default_nettype none

package noc_pkg;

    // Flit geometry
    localparam int NOC_DW   = 32;
    localparam int SAMPLE_W = 18;
    localparam int SEQ_W    = NOC_DW - SAMPLE_W;

    // Ramp increment per injected flit
    localparam int ACC_STEP = 4;

    // Symmetric four-tap smoothing kernel, newest sample first
    localparam int NUM_TAPS = 4;
    localparam int FIR_COEF [NUM_TAPS] = '{1, 2, 2, 1};

    // Base key of the per-hop mix, offset by the hop index
    localparam logic [SAMPLE_W-1:0] HOP_KEY = 18'h2D5A3;

    // One 32-bit word on the wire, seq in the old pad bits
    typedef struct packed {
        logic [SEQ_W-1:0]    seq;
        logic [SAMPLE_W-1:0] sample;
    } flit_t;

    // Downstream half of a link, ready travels back on its own
    typedef struct packed {
        logic  valid;
        flit_t flit;
    } link_t;

endpackage

`default_nettype wire

// File: verilog/pipe_reg.sv
`default_nettype none

module pipe_reg (
    input  logic           clk,
    input  logic           reset,
    input  noc_pkg::link_t in_link,
    output logic           in_ready,
    output noc_pkg::link_t out_link,
    input  logic           out_ready
);

    logic           valid_q;
    noc_pkg::flit_t flit_q;
    logic           load;

    // Accept when empty, or when the held flit leaves on this edge
    assign in_ready = !valid_q || out_ready;
    assign load     = in_link.valid && in_ready;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else if (in_ready) begin
            valid_q <= in_link.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            flit_q <= in_link.flit;
        end
    end

    assign out_link = '{valid: valid_q, flit: flit_q};

endmodule

`default_nettype wire

// File: verilog/traffic_gen.sv
`default_nettype none

module traffic_gen (
    input  logic           clk,
    input  logic           reset,
    input  logic           enable,
    output noc_pkg::link_t out_link,
    input  logic           out_ready
);

    logic [noc_pkg::SAMPLE_W-1:0] ramp;
    logic [noc_pkg::SEQ_W-1:0]    seq;
    logic [noc_pkg::SAMPLE_W-1:0] fir_sum;

    // Output register
    logic           valid_q;
    noc_pkg::flit_t flit_q;

    logic out_free;
    logic load;

    // Register can take a new flit when empty or draining this cycle
    assign out_free = !valid_q || out_ready;
    assign load     = enable && out_free;

    fir_filter fir_filter_inst (
        .clk       (clk),
        .reset     (reset),
        .shift     (load),
        .sample_in (ramp),
        .sum_out   (fir_sum)
    );

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid_q <= 1'b0;
            ramp    <= '0;
            seq     <= '0;
        end else begin
            if (out_free) begin
                valid_q <= enable;
            end
            // Ramp and seq only move when a flit is loaded
            if (load) begin
                ramp <= ramp + noc_pkg::SAMPLE_W'(noc_pkg::ACC_STEP);
                seq  <= seq + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            flit_q <= '{seq: seq, sample: fir_sum};
        end
    end

    assign out_link = '{valid: valid_q, flit: flit_q};

endmodule

`default_nettype wire

// File: verilog/traffic_sink.sv
`default_nettype none

module traffic_sink (
    input  logic           clk,
    input  logic           reset,
    input  noc_pkg::link_t in_link,
    output logic           in_ready,
    output noc_pkg::link_t out_link,
    input  logic           out_ready,
    output logic           seq_error,
    output logic [31:0]    flit_count
);

    logic [noc_pkg::SEQ_W-1:0] expected_seq;
    logic                      in_xfer;

    // Delivery register in front of the top outputs
    pipe_reg out_reg_inst (
        .clk       (clk),
        .reset     (reset),
        .in_link   (in_link),
        .in_ready  (in_ready),
        .out_link  (out_link),
        .out_ready (out_ready)
    );

    assign in_xfer = in_link.valid && in_ready;

    // Sequence check, sticky until reset
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            expected_seq <= '0;
            seq_error    <= 1'b0;
        end else if (in_xfer) begin
            expected_seq <= expected_seq + 1'b1;
            if (in_link.flit.seq != expected_seq) begin
                seq_error <= 1'b1;
            end
        end
    end

    // Accepted flits
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            flit_count <= '0;
        end else if (in_xfer) begin
            flit_count <= flit_count + 32'd1;
        end
    end

endmodule

`default_nettype wire
